//--- src/arithPkg.sv
package arithPkg;

  // **************************************************
  // Widths
  // **************************************************
  localparam int operandWidth = 8;
  localparam int nibbleWidth  = 4;
  localparam int productWidth = 16;

  typedef logic [operandWidth-1:0]  operand_t;
  typedef logic [nibbleWidth-1:0]   nibble_t;
  typedef logic [2*nibbleWidth-1:0] quadProd_t;
  typedef logic [productWidth-1:0]  product_t;

  // Three always-exact quadrants
  typedef struct packed {
    quadProd_t hiLo;
    quadProd_t loHi;
    quadProd_t hiHi;
  } quadSet_t;

  // **************************************************
  // Adder cells, result is {carry, sum}
  // **************************************************
  function automatic logic [1:0] fullAdd(input logic a, input logic b, input logic cin);
    fullAdd = {(a & b) | ((a ^ b) & cin), a ^ b ^ cin};
  endfunction

  function automatic logic [1:0] halfAdd(input logic a, input logic b);
    halfAdd = {a & b, a ^ b};
  endfunction

  // **************************************************
  // 2x2 multiplier cells
  // **************************************************
  function automatic nibble_t mul2Exact(input logic [1:0] c, input logic [1:0] d);
    logic crossA;
    logic crossB;
    logic topAnd;
    logic midCarry;
    crossA   = c[0] & d[1];
    crossB   = c[1] & d[0];
    topAnd   = c[1] & d[1];
    // Carry out of the middle column
    midCarry = crossA & crossB;
    mul2Exact = {topAnd & midCarry, topAnd ^ midCarry, crossA ^ crossB, c[0] & d[0]};
  endfunction

  // Middle bit comes straight from the multiplier high bit
  function automatic nibble_t mul2Approx(input logic [1:0] c, input logic [1:0] d);
    mul2Approx = {1'b0, c[1] & d[1], d[1], c[0] & d[0]};
  endfunction

  // **************************************************
  // 4x4 quadrant from four cell products
  // **************************************************
  // p0 = lo*lo, p1 = hi*lo, p2 = lo*hi, p3 = hi*hi
  function automatic quadProd_t reduce4(input nibble_t p0, input nibble_t p1,
                                        input nibble_t p2, input nibble_t p3);
    logic [1:0] comp0;
    logic [1:0] comp1;
    logic [1:0] comp2;
    logic [1:0] comp3;
    logic [1:0] rip3;
    logic [1:0] rip4;
    logic [1:0] rip5;
    logic [1:0] rip6;
    // Column compression
    comp0 = fullAdd(p0[2], p1[0], p2[0]);
    comp1 = fullAdd(p0[3], p1[1], p2[1]);
    comp2 = fullAdd(p1[2], p2[2], p3[0]);
    comp3 = fullAdd(p1[3], p2[3], p3[1]);
    // Final ripple
    rip3 = halfAdd(comp1[0], comp0[1]);
    rip4 = fullAdd(comp2[0], comp1[1], rip3[1]);
    rip5 = fullAdd(comp3[0], comp2[1], rip4[1]);
    rip6 = fullAdd(p3[2], comp3[1], rip5[1]);
    // Top carry cannot occur, product fits in 8 bits
    reduce4 = {p3[3] ^ rip6[1], rip6[0], rip5[0], rip4[0], rip3[0], comp0[0], p0[1:0]};
  endfunction

endpackage

//--- src/ctrlPkg.sv
package ctrlPkg;

  // **************************************************
  // Operation mode
  // **************************************************
  // Selects the low-by-low quadrant cells
  typedef enum logic {
    modeExact  = 1'b0,
    modeApprox = 1'b1
  } mulMode_t;

  // **************************************************
  // Request and result
  // **************************************************
  // 17 bits in total
  typedef struct packed {
    mulMode_t           mode;
    arithPkg::operand_t multiplicand;
    arithPkg::operand_t multiplier;
  } mulReq_t;

  typedef struct packed {
    arithPkg::product_t product;
  } mulRes_t;

endpackage

//--- src/approxQuadrant.sv
`timescale 1ns/10ps

module approxQuadrant (
  input  logic                clk,
  input  logic                rst,
  input  ctrlPkg::mulReq_t    req,
  input  logic                inValid,
  output arithPkg::quadProd_t quadLo
);
  import arithPkg::*;
  import ctrlPkg::*;

  // Low nibbles of both operands
  nibble_t   aLo;
  nibble_t   bLo;
  // Cell products, lo*lo, hi*lo, lo*hi, hi*hi
  nibble_t   cellLL;
  nibble_t   cellHL;
  nibble_t   cellLH;
  nibble_t   cellHH;
  quadProd_t quadNext;

  assign aLo = req.multiplicand[nibbleWidth-1:0];
  assign bLo = req.multiplier[nibbleWidth-1:0];

  // **************************************************
  // Cell selection by mode
  // **************************************************
  always_comb begin
    if (req.mode == modeApprox) begin
      cellLL = mul2Approx(aLo[1:0], bLo[1:0]);
      cellHL = mul2Approx(aLo[3:2], bLo[1:0]);
      cellLH = mul2Approx(aLo[1:0], bLo[3:2]);
      cellHH = mul2Approx(aLo[3:2], bLo[3:2]);
    end else begin
      cellLL = mul2Exact(aLo[1:0], bLo[1:0]);
      cellHL = mul2Exact(aLo[3:2], bLo[1:0]);
      cellLH = mul2Exact(aLo[1:0], bLo[3:2]);
      cellHH = mul2Exact(aLo[3:2], bLo[3:2]);
    end
  end

  // Same compressor shape for both modes
  assign quadNext = reduce4(cellLL, cellHL, cellLH, cellHH);

  // **************************************************
  // Stage one register
  // **************************************************
  always_ff @(posedge clk) begin
    if (rst) begin
      quadLo <= '0;
    end else if (inValid) begin
      quadLo <= quadNext;
    end
  end

  // Exact mode must give the true nibble product one cycle later
  exactLowProduct: assert property (
    @(posedge clk) disable iff (rst)
      (inValid && req.mode == modeExact) |=>
        (quadLo == quadProd_t'($past(aLo)) * quadProd_t'($past(bLo)))
  ) else $error("Low quadrant wrong in exact mode");

endmodule

//--- src/exactQuadrants.sv
`timescale 1ns/10ps

module exactQuadrants (
  input  logic               clk,
  input  logic               rst,
  input  ctrlPkg::mulReq_t   req,
  input  logic               inValid,
  output arithPkg::quadSet_t quads,
  output logic               stageValid
);
  import arithPkg::*;

  nibble_t  aLo;
  nibble_t  aHi;
  nibble_t  bLo;
  nibble_t  bHi;
  quadSet_t quadsNext;

  // One full exact 4x4 quadrant
  function automatic quadProd_t exactQuad(input nibble_t c, input nibble_t d);
    exactQuad = reduce4(mul2Exact(c[1:0], d[1:0]), mul2Exact(c[3:2], d[1:0]),
                        mul2Exact(c[1:0], d[3:2]), mul2Exact(c[3:2], d[3:2]));
  endfunction

  // Operand split
  assign aLo = req.multiplicand[nibbleWidth-1:0];
  assign aHi = req.multiplicand[operandWidth-1:nibbleWidth];
  assign bLo = req.multiplier[nibbleWidth-1:0];
  assign bHi = req.multiplier[operandWidth-1:nibbleWidth];

  // **************************************************
  // Exact quadrants
  // **************************************************
  assign quadsNext.hiLo = exactQuad(aHi, bLo);
  assign quadsNext.loHi = exactQuad(aLo, bHi);
  assign quadsNext.hiHi = exactQuad(aHi, bHi);

  // **************************************************
  // Stage one register and valid
  // **************************************************
  always_ff @(posedge clk) begin
    if (rst) begin
      quads      <= '0;
      stageValid <= 1'b0;
    end else begin
      // Valid follows inValid every cycle
      stageValid <= inValid;
      if (inValid) begin
        quads <= quadsNext;
      end
    end
  end

  // Pipeline empty right after reset
  validClearedByReset: assert property (
    @(posedge clk) rst |=> !stageValid
  ) else $error("Stage valid set in the cycle after reset");

endmodule

//--- src/productReducer.sv
`timescale 1ns/10ps

module productReducer (
  input  logic                clk,
  input  logic                rst,
  input  arithPkg::quadProd_t quadLo,
  input  arithPkg::quadSet_t  quads,
  input  logic                stageValid,
  output ctrlPkg::mulRes_t    res,
  output logic                outValid
);
  import arithPkg::*;

  // Column sums and carries of the compression stage
  logic [7:0]  colSum;
  logic [7:0]  colCarry;
  // Ripple carries, indexed by the product bit that produced them
  logic [14:5] chain;
  product_t    sum;

  // **************************************************
  // Column compression
  // **************************************************
  always_comb begin
    for (int i = 0; i < 4; i++) begin
      // Bits 4 to 7, low quadrant upper half with the two cross quadrants
      {colCarry[i], colSum[i]} = fullAdd(quadLo[i+4], quads.hiLo[i], quads.loHi[i]);
      // Bits 8 to 11, cross quadrants upper half with the high quadrant
      {colCarry[i+4], colSum[i+4]} = fullAdd(quads.hiLo[i+4], quads.loHi[i+4],
                                             quads.hiHi[i]);
    end
  end

  // **************************************************
  // Final ripple addition
  // **************************************************
  always_comb begin
    // Low bits pass through
    sum[3:0] = quadLo[3:0];
    sum[4]   = colSum[0];
    {chain[5], sum[5]} = halfAdd(colSum[1], colCarry[0]);
    for (int k = 6; k <= 11; k++) begin
      {chain[k], sum[k]} = fullAdd(colSum[k-4], colCarry[k-5], chain[k-1]);
    end
    {chain[12], sum[12]} = fullAdd(quads.hiHi[4], colCarry[7], chain[11]);
    {chain[13], sum[13]} = halfAdd(quads.hiHi[5], chain[12]);
    {chain[14], sum[14]} = halfAdd(quads.hiHi[6], chain[13]);
    // No carry out of the top bit
    sum[15] = quads.hiHi[7] ^ chain[14];
  end

  // **************************************************
  // Output register
  // **************************************************
  always_ff @(posedge clk) begin
    if (rst) begin
      res      <= '0;
      outValid <= 1'b0;
    end else begin
      outValid <= stageValid;
      // Hold last product on idle cycles
      if (stageValid) begin
        res.product <= sum;
      end
    end
  end

  // Every result traces back to a filled stage one
  outValidFromStage: assert property (
    @(posedge clk) disable iff (rst)
      outValid |-> $past(stageValid)
  ) else $error("Output valid without a stage one operation");

endmodule

//--- src/approxMul8.sv
`timescale 1ns/10ps

module approxMul8 (
  input  logic             clk,
  input  logic             rst,
  input  ctrlPkg::mulReq_t req,
  input  logic             inValid,
  output ctrlPkg::mulRes_t res,
  output logic             outValid
);
  import arithPkg::*;

  // Stage one results
  quadProd_t quadLo;
  quadSet_t  quads;
  logic      stageValid;

  // Mode-selectable low-by-low quadrant
  approxQuadrant uLowQuad (
    .clk     (clk),
    .rst     (rst),
    .req     (req),
    .inValid (inValid),
    .quadLo  (quadLo)
  );

  // Remaining three quadrants and the stage valid
  exactQuadrants uExactQuads (
    .clk        (clk),
    .rst        (rst),
    .req        (req),
    .inValid    (inValid),
    .quads      (quads),
    .stageValid (stageValid)
  );

  // Reduction, final add and output stage
  productReducer uReducer (
    .clk        (clk),
    .rst        (rst),
    .quadLo     (quadLo),
    .quads      (quads),
    .stageValid (stageValid),
    .res        (res),
    .outValid   (outValid)
  );

endmodule

//--- verif/clkGen.sv
`timescale 1ns/10ps

module clkGen (
  output logic clk
);
  // Half of the 40 ns period
  localparam realtime halfPeriod = 20.0;

  // Free-running clock, starts low
  initial begin
    clk = 1'b0;
    forever begin
      #halfPeriod clk = ~clk;
    end
  end

endmodule

//--- verif/tbApproxMul8.sv
`timescale 1ns/10ps

module tbApproxMul8;
  import arithPkg::*;
  import ctrlPkg::*;

  // Inputs change this long after the rising edge
  localparam realtime driveDelay = 1.0;
  // Cycles allowed for the pipeline to empty
  localparam int drainLimit = 20;

  logic             clk;
  logic             rst;
  mulReq_t          req;
  logic             inValid;
  mulRes_t          res;
  logic             outValid;

  // Delayed inValid whose bit 1 lines up with outValid
  logic [1:0]       validPipe;
  mulRes_t          expQ[$];
  string            nameQ[$];
  string            phase;
  int               valueErrors;
  int               otherErrors;

  clkGen uClk (
    .clk (clk)
  );

  approxMul8 UUT (
    .clk      (clk),
    .rst      (rst),
    .req      (req),
    .inValid  (inValid),
    .res      (res),
    .outValid (outValid)
  );

  // **************************************************
  // Reference model
  // **************************************************
  // Low AND low, twice the multiplier high bit, four times high AND high
  function automatic int approxCell(input int c, input int d);
    approxCell = (c & d & 1) + 2 * ((d >> 1) & 1) + 4 * ((c >> 1) & (d >> 1) & 1);
  endfunction

  function automatic product_t modelProduct(input mulMode_t mode, input operand_t a,
                                            input operand_t b);
    int aLo;
    int aHi;
    int bLo;
    int bHi;
    int lowQuad;
    aLo = int'(a) & 15;
    aHi = int'(a) >> 4;
    bLo = int'(b) & 15;
    bHi = int'(b) >> 4;
    if (mode == modeExact) begin
      modelProduct = product_t'(int'(a) * int'(b));
    end else begin
      // Four approximate cells, each at its own position
      lowQuad = approxCell(aLo & 3, bLo & 3)
              + 4 * approxCell(aLo >> 2, bLo & 3)
              + 4 * approxCell(aLo & 3, bLo >> 2)
              + 16 * approxCell(aLo >> 2, bLo >> 2);
      modelProduct = product_t'(lowQuad + 16 * (aHi * bLo + aLo * bHi) + 256 * aHi * bHi);
    end
  endfunction

  // **************************************************
  // Compare tasks
  // **************************************************
  task automatic productCheck(input string testName, input mulRes_t expRes,
                              input mulRes_t actRes);
    if (actRes !== expRes) begin
      valueErrors++;
      $display("ERR %s expected %h actual %h", testName, expRes.product, actRes.product);
    end
  endtask

  task automatic validCheck(input string testName, input logic expValid,
                            input logic actValid);
    if (actValid !== expValid) begin
      valueErrors++;
      $display("ERR %s outValid expected %b actual %b", testName, expValid, actValid);
    end
  endtask

  // One clock, then the drive delay
  task automatic stepCycle();
    @(posedge clk);
    #driveDelay;
  endtask

  task automatic drainPipe();
    int waited;
    waited = 0;
    while (expQ.size() != 0 && waited < drainLimit) begin
      stepCycle();
      waited++;
    end
    if (expQ.size() != 0) begin
      $display("Timeout: %0d results never left the pipeline", expQ.size());
      otherErrors++;
    end
  endtask

  // **************************************************
  // Monitor
  // **************************************************
  always @(posedge clk) begin
    if (rst) begin
      validPipe <= '0;
    end else begin
      validPipe <= {validPipe[0], inValid};
    end
  end

  // Outputs settled by the falling edge
  always @(negedge clk) begin
    if (!rst) begin
      validCheck(phase, validPipe[1], outValid);
      if (outValid) begin
        if (expQ.size() == 0) begin
          $display("Result appeared while no operation was outstanding");
          otherErrors++;
        end else begin
          productCheck(nameQ.pop_front(), expQ.pop_front(), res);
        end
      end
    end
  end

  // **************************************************
  // Stimulus from the trace
  // **************************************************
  initial begin
    int          fd;
    int          fields;
    int          lineNo;
    string       line;
    logic [31:0] fMode;
    logic [31:0] fA;
    logic [31:0] fB;
    logic [31:0] fP;
    logic [31:0] fGap;
    mulMode_t    mode;
    mulRes_t     expRes;
    rst         = 1'b1;
    req         = '0;
    inValid     = 1'b0;
    valueErrors = 0;
    otherErrors = 0;
    lineNo      = 0;
    phase       = "reset idle";
    repeat (10) stepCycle();
    rst = 1'b0;
    // Nothing presented yet, outValid must stay low
    repeat (4) stepCycle();
    phase = "trace";
    fd = $fopen("verif/mulTrace.txt", "r");
    if (fd == 0) begin
      $display("Could not open the trace file verif/mulTrace.txt");
      otherErrors++;
    end else begin
      while (!$feof(fd)) begin
        line = "";
        void'($fgets(line, fd));
        lineNo++;
        fields = $sscanf(line, "%h %h %h %h %h", fMode, fA, fB, fP, fGap);
        if (fields == 5) begin
          mode = mulMode_t'(fMode[0]);
          expRes.product = product_t'(fP[15:0]);
          // Trace value must agree with the product rule
          if (expRes.product !== modelProduct(mode, fA[7:0], fB[7:0])) begin
            $display("Trace line %0d holds %h but the product rule gives %h", lineNo,
                     expRes.product, modelProduct(mode, fA[7:0], fB[7:0]));
            otherErrors++;
          end
          req.mode         = mode;
          req.multiplicand = fA[7:0];
          req.multiplier   = fB[7:0];
          inValid          = 1'b1;
          expQ.push_back(expRes);
          nameQ.push_back($sformatf("line %0d %s %h*%h", lineNo, mode.name(),
                                    fA[7:0], fB[7:0]));
          stepCycle();
          // Idle gap after this operation
          inValid = 1'b0;
          repeat (fGap) stepCycle();
        end else if (fields > 0) begin
          $display("Trace line %0d is malformed and was skipped", lineNo);
          otherErrors++;
        end
      end
      $fclose(fd);
    end
    inValid = 1'b0;
    phase   = "drain";
    drainPipe();
    // Pipeline empty, outValid must fall again
    repeat (3) stepCycle();
    $display("Errors: %0d value mismatches, %0d other failures", valueErrors, otherErrors);
    if (valueErrors == 0 && otherErrors == 0) begin
      $display("=== PASS ===");
    end else begin
      $display("=== FAIL ===");
    end
    $finish;
  end

endmodule

//--- verif/mulTrace.txt
// mode multiplicand multiplier product idle, all hex
// mode 0 exact, 1 approximate; idle is the number of idle cycles after the operation
// Exact corner cases
0 00 00 0000 0
0 ff ff fe01 0
0 01 01 0001 0
0 80 80 4000 0
0 01 ff 00ff 0
0 ff 01 00ff 0
0 0f 0f 00e1 0
0 f0 0f 0e10 0
0 12 34 03a8 0
0 ab cd 88ef 0
0 02 40 0080 0
0 10 10 0100 0
0 7f 3c 1dc4 0
0 55 aa 3872 2
// Approximate low quadrant
1 00 02 000a 0
1 00 00 0000 0
1 ff ff fdcf 0
1 03 03 000f 0
1 01 01 0001 0
1 02 02 000e 1
1 10 10 0100 0
1 0f 01 0005 0
1 01 0f 0037 0
1 12 34 03a0 0
1 ab cd 88dd 3
1 55 aa 3872 0
1 07 07 0027 0
1 0c 0c 0078 0
1 f0 0f 0e42 0
1 80 80 4000 0
1 09 06 001e 0
1 3c 7f 1da6 1
// Back to back, mode alternating
0 09 06 0036 0
1 09 06 001e 0
0 07 07 0031 0
1 07 07 0027 0
0 03 03 0009 0
1 03 03 000f 0
0 0c 0c 0090 0
1 0c 0c 0078 0
0 ab cd 88ef 0
1 ab cd 88dd 0
0 3c 7f 1dc4 0
1 3c 7f 1da6 0

//--- build.f
src/arithPkg.sv
src/ctrlPkg.sv
src/approxQuadrant.sv
src/exactQuadrants.sv
src/productReducer.sv
src/approxMul8.sv
verif/clkGen.sv
verif/tbApproxMul8.sv

//--- Makefile
# Verilator build and run for the approximate multiplier
TOP = tbApproxMul8

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --assert -j 0 -f build.f --top-module $(TOP) -Mdir obj_dir

# The log decides the verdict
run: build
	./obj_dir/V$(TOP) > sim.log 2>&1 || true
	cat sim.log
	@if grep -q "=== FAIL ===" sim.log; then \
	  echo "Simulation reported failure"; exit 1; \
	fi
	@if ! grep -q "=== PASS ===" sim.log; then \
	  echo "Simulation ended without a verdict"; exit 1; \
	fi

lint:
	verilator --lint-only -Wall --timing -f build.f --top-module $(TOP)

clean:
	rm -rf obj_dir sim.log
